/* src.f */
+incdir+include
hdl/rvfi_trace_pkg.sv
hdl/rv32_insn_decoder.sv
hdl/rvc_insn_decoder.sv
hdl/trace_record_unit.sv
hdl/rvfi_tracer.sv
test/rvfi_tracer_tb.sv

/* run_sim.sh */
#!/bin/sh
# Builds the tracer testbench with Verilator and runs it
set -e

cd "$(dirname "$0")"

verilator --binary --timing --timescale 1ns/1ns \
  -f src.f \
  --top-module rvfi_tracer_tb \
  --Mdir obj_dir \
  -o rvfi_tracer_sim

output=$(./obj_dir/rvfi_tracer_sim 2>&1 || true)
echo "$output"

if echo "$output" | grep -qx "TEST PASSED"; then
  exit 0
else
  exit 1
fi

/* test/rvfi_tracer_tb.sv */
// ******************************
// Retirement tracer testbench
// Random RV32 and RV32C retirements
// checked against an encoder model
// with a one cycle record latency
// ******************************

`timescale 1ns/1ns

`include "rvfi_trace_params.svh"

module rvfi_tracer_tb;

  import rvfi_trace_pkg::*;

  localparam int XLEN          = `TRACE_XLEN;
  localparam int CLK_PERIOD_NS = 4;
  localparam int RESET_CYCLES  = 8;
  localparam int NUM_CYCLES    = 4000;
  localparam int RAND_SEED     = 42617;
  localparam int TOTAL_CYCLES  = RESET_CYCLES + NUM_CYCLES + 2;
  localparam int WATCHDOG_NS   = TOTAL_CYCLES * CLK_PERIOD_NS * 3 / 2;

  // funct3 and funct12 choices, packed lowest entry first
  localparam logic [14:0] LOAD_F3    = {3'd5, 3'd4, 3'd2, 3'd1, 3'd0};
  localparam logic [17:0] BRANCH_F3  = {3'd7, 3'd6, 3'd5, 3'd4, 3'd1, 3'd0};
  localparam logic [17:0] OPIMM_F3   = {3'd7, 3'd6, 3'd4, 3'd3, 3'd2, 3'd0};
  localparam logic [8:0]  BAD_LD_F3  = {3'd7, 3'd6, 3'd3};
  localparam logic [59:0] SYS_F12    = {12'h105, 12'h7b2, 12'h302, 12'h001, 12'h000};
  // Major opcodes with no decode
  localparam logic [39:0] RSV_OPC    = {5'b10110, 5'b10100, 5'b10000, 5'b01010,
                                        5'b01001, 5'b00111, 5'b00010, 5'b00001};

  logic          clk_i = 1'b0;
  logic          rst_ni;
  logic          rvfi_valid;
  xlen_t         rvfi_pc_rdata;
  xlen_t         rvfi_insn;
  trace_record_t record;

  trace_record_t exp_q[$];
  cycle_t        model_cycle;
  int unsigned   seed_ret;

  rvfi_tracer rvfi_tracer_inst (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .rvfi_valid    (rvfi_valid),
    .rvfi_pc_rdata (rvfi_pc_rdata),
    .rvfi_insn     (rvfi_insn),
    .record        (record)
  );

  always #(CLK_PERIOD_NS / 2) clk_i = ~clk_i;

  task automatic stop_on_error(input string msg);
    $display("error at %0t ns: %s", $time, msg);
    $display("TEST FAILED");
    $fatal(1, "stopped at the first mismatch");
  endtask

  task automatic check_class(input insn_class_e got, input insn_class_e exp, input string what);
    if (got !== exp) begin
      stop_on_error($sformatf("%s is %s, expected %s", what, got.name(), exp.name()));
    end
  endtask

  task automatic check_mask(input access_mask_t got, input access_mask_t exp, input string what);
    if (got !== exp) begin
      stop_on_error($sformatf("%s is %b, expected %b", what, got, exp));
    end
  endtask

  task automatic check_word(input xlen_t got, input xlen_t exp, input string what);
    if (got !== exp) begin
      stop_on_error($sformatf("%s is %08h, expected %08h", what, got, exp));
    end
  endtask

  task automatic check_cycle(input cycle_t got, input cycle_t exp, input string what);
    if (got !== exp) begin
      stop_on_error($sformatf("%s is %0d, expected %0d", what, got, exp));
    end
  endtask

  task automatic check_flag(input logic got, input logic exp, input string what);
    if (got !== exp) begin
      stop_on_error($sformatf("%s is %b, expected %b", what, got, exp));
    end
  endtask

  // Low bits of v taken as a signed field of the given width
  function automatic xlen_t sext(input xlen_t v, input int unsigned bits);
    xlen_t shifted;
    shifted = v << (XLEN - bits);
    return xlen_t'($signed(shifted) >>> (XLEN - bits));
  endfunction

  // 32-bit templates, the immediate is picked first and then scattered
  task automatic gen_full(output xlen_t w, output insn_class_e cls, output access_mask_t m,
                          output xlen_t imm);
    xlen_t       x;
    xlen_t       r;
    xlen_t       iv;
    logic [2:0]  f3;
    logic [6:0]  f7;
    int unsigned k2;
    x   = $urandom;
    r   = $urandom;
    iv  = sext(r, 12);
    w   = '0;
    cls = INVALID;
    m   = MASK_NONE;
    imm = '0;
    case ($urandom_range(11, 0))
      0: begin
        w   = {r[31:12], x[11:7], x[0] ? 7'b0110111 : 7'b0010111};
        cls = UPPER;
        m   = MASK_RD;
        imm = {r[31:12], 12'b0};
      end
      1: begin
        imm = sext({r[31:1], 1'b0}, 21);
        w   = {imm[20], imm[10:1], imm[11], imm[19:12], x[11:7], 7'b1101111};
        cls = JUMP;
        m   = MASK_RD;
      end
      2: begin
        w   = {iv[11:0], x[19:15], 3'b000, x[11:7], 7'b1100111};
        cls = JUMP_REG;
        m   = MASK_RS1 | MASK_RD;
        imm = iv;
      end
      3: begin
        k2  = $urandom_range(5, 0);
        f3  = BRANCH_F3[3*k2 +: 3];
        imm = sext({r[31:1], 1'b0}, 13);
        w   = {imm[12], imm[10:5], x[24:20], x[19:15], f3, imm[4:1], imm[11], 7'b1100011};
        cls = BRANCH;
        m   = MASK_RS1 | MASK_RS2;
      end
      4: begin
        k2  = $urandom_range(4, 0);
        f3  = LOAD_F3[3*k2 +: 3];
        w   = {iv[11:0], x[19:15], f3, x[11:7], 7'b0000011};
        cls = LOAD;
        m   = MASK_RS1 | MASK_RD | MASK_MEM;
        imm = iv;
      end
      5: begin
        f3  = 3'($urandom_range(2, 0));
        w   = {iv[11:5], x[24:20], x[19:15], f3, iv[4:0], 7'b0100011};
        cls = STORE;
        m   = MASK_RS1 | MASK_RS2 | MASK_MEM;
        imm = iv;
      end
      6: begin
        k2  = $urandom_range(5, 0);
        f3  = OPIMM_F3[3*k2 +: 3];
        w   = {iv[11:0], x[19:15], f3, x[11:7], 7'b0010011};
        cls = OP_IMM;
        m   = MASK_RS1 | MASK_RD;
        imm = iv;
      end
      7: begin
        // slli, srli, srai
        k2  = $urandom_range(2, 0);
        f3  = (k2 == 0) ? 3'b001 : 3'b101;
        f7  = (k2 == 2) ? 7'b0100000 : 7'b0000000;
        w   = {f7, r[4:0], x[19:15], f3, x[11:7], 7'b0010011};
        cls = OP_SHIFT_IMM;
        m   = MASK_RS1 | MASK_RD;
        imm = xlen_t'(r[4:0]);
      end
      8: begin
        // Base ALU, M group, sub and sra
        k2  = $urandom_range(2, 0);
        f3  = x[14:12];
        f7  = (k2 == 1) ? 7'b0000001 : 7'b0000000;
        if (k2 == 2) begin
          f7 = 7'b0100000;
          f3 = x[12] ? 3'b101 : 3'b000;
        end
        w   = {f7, x[24:20], x[19:15], f3, x[11:7], 7'b0110011};
        cls = OP_REG;
        m   = MASK_RS1 | MASK_RS2 | MASK_RD;
      end
      9: begin
        f3  = 3'($urandom_range(3, 1));
        w   = {iv[11:0], x[19:15], f3, x[11:7], 7'b1110011};
        cls = CSR_REG;
        m   = MASK_RS1 | MASK_RD;
        imm = iv;
      end
      10: begin
        f3  = 3'($urandom_range(7, 5));
        w   = {r[11:0], x[19:15], f3, x[11:7], 7'b1110011};
        cls = CSR_IMM;
        m   = MASK_RD;
        imm = xlen_t'(x[19:15]);
      end
      default: begin
        if (x[0]) begin
          // fence or fence.i
          w   = {x[31:15], x[1] ? 3'b001 : 3'b000, x[11:7], 7'b0001111};
          cls = x[1] ? SYSTEM : FENCE;
        end else begin
          k2  = $urandom_range(4, 0);
          w   = {SYS_F12[12*k2 +: 12], 13'b0, 7'b1110011};
          cls = SYSTEM;
        end
      end
    endcase
  endtask

  // RV32C templates, upper half of the word left random
  task automatic gen_comp(output xlen_t w, output insn_class_e cls, output access_mask_t m,
                          output xlen_t imm);
    xlen_t       x;
    xlen_t       r;
    xlen_t       v;
    logic [15:0] h;
    reg_addr_t   rdnz;
    reg_addr_t   rs2nz;
    x     = $urandom;
    r     = $urandom;
    rdnz  = (x[11:7] == 5'd0) ? 5'd1 : x[11:7];
    rs2nz = (x[6:2] == 5'd0) ? 5'd1 : x[6:2];
    h     = '0;
    cls   = INVALID;
    m     = MASK_NONE;
    imm   = '0;
    case ($urandom_range(19, 0))
      0: begin
        v = {22'b0, r[9:2], 2'b00};
        if (v == '0) begin
          v = 32'd4;
        end
        h   = {3'b000, v[5:4], v[9:6], v[2], v[3], x[4:2], 2'b00};
        cls = OP_IMM;
        m   = MASK_RD;
        imm = v;
      end
      1, 2: begin
        v = {25'b0, r[6:2], 2'b00};
        h = {x[0] ? 3'b110 : 3'b010, v[5:3], x[9:7], v[2], v[6], x[4:2], 2'b00};
        cls = x[0] ? STORE : LOAD;
        m   = x[0] ? (MASK_RS1 | MASK_RS2 | MASK_MEM) : (MASK_RS1 | MASK_RD | MASK_MEM);
        imm = v;
      end
      3, 4: begin
        // c.addi or c.li
        v   = sext(r, 6);
        h   = {x[0] ? 3'b010 : 3'b000, v[5], x[11:7], v[4:0], 2'b01};
        cls = OP_IMM;
        m   = x[0] ? MASK_RD : (MASK_RS1 | MASK_RD);
        imm = v;
      end
      5: begin
        // c.jal or c.j
        v = sext({r[31:1], 1'b0}, 12);
        h = {x[0] ? 3'b001 : 3'b101, v[11], v[4], v[9:8], v[10], v[6], v[7], v[3:1], v[5], 2'b01};
        cls = JUMP;
        m   = x[0] ? MASK_RD : MASK_NONE;
        imm = v;
      end
      6: begin
        v = sext({r[31:4], 4'b0}, 10);
        if (v == '0) begin
          v = 32'd16;
        end
        h   = {3'b011, v[9], 5'd2, v[4], v[6], v[8:7], v[5], 2'b01};
        cls = OP_IMM;
        m   = MASK_RS1 | MASK_RD;
        imm = v;
      end
      7: begin
        v = sext({r[31:12], 12'b0}, 18);
        if (v == '0) begin
          v = 32'h0000_1000;
        end
        rdnz = (rdnz == 5'd2) ? 5'd5 : rdnz;
        h    = {3'b011, v[17], rdnz, v[16:12], 2'b01};
        cls  = UPPER;
        m    = MASK_RD;
        imm  = v;
      end
      8: begin
        // c.srli or c.srai
        h   = {3'b100, 1'b0, x[0] ? 2'b01 : 2'b00, x[9:7], r[4:0], 2'b01};
        cls = OP_SHIFT_IMM;
        m   = MASK_RS1 | MASK_RD;
        imm = xlen_t'(r[4:0]);
      end
      9: begin
        v   = sext(r, 6);
        h   = {3'b100, v[5], 2'b10, x[9:7], v[4:0], 2'b01};
        cls = OP_IMM;
        m   = MASK_RS1 | MASK_RD;
        imm = v;
      end
      10: begin
        h   = {3'b100, 1'b0, 2'b11, x[9:7], x[6:5], x[4:2], 2'b01};
        cls = OP_REG;
        m   = MASK_RS1 | MASK_RS2 | MASK_RD;
      end
      11: begin
        v   = sext({r[31:1], 1'b0}, 9);
        h   = {x[0] ? 3'b111 : 3'b110, v[8], v[4:3], x[9:7], v[7:6], v[2:1], v[5], 2'b01};
        cls = BRANCH;
        m   = MASK_RS1;
        imm = v;
      end
      12: begin
        h   = {3'b000, 1'b0, x[11:7], r[4:0], 2'b10};
        cls = OP_SHIFT_IMM;
        m   = MASK_RS1 | MASK_RD;
        imm = xlen_t'(r[4:0]);
      end
      13: begin
        v   = {24'b0, r[7:2], 2'b00};
        h   = {3'b010, v[5], rdnz, v[4:2], v[7:6], 2'b10};
        cls = LOAD;
        m   = MASK_RS1 | MASK_RD | MASK_MEM;
        imm = v;
      end
      14: begin
        v   = {24'b0, r[7:2], 2'b00};
        h   = {3'b110, v[5:2], v[7:6], x[6:2], 2'b10};
        cls = STORE;
        m   = MASK_RS1 | MASK_RS2 | MASK_MEM;
        imm = v;
      end
      15: begin
        h   = {4'b1000, rdnz, 5'd0, 2'b10};
        cls = JUMP_REG;
        m   = MASK_RS1;
      end
      16: begin
        h   = {4'b1000, x[11:7], rs2nz, 2'b10};
        cls = OP_REG;
        m   = MASK_RS2 | MASK_RD;
      end
      17: begin
        h   = {4'b1001, 10'b0, 2'b10};
        cls = SYSTEM;
      end
      18: begin
        h   = {4'b1001, rdnz, 5'd0, 2'b10};
        cls = JUMP_REG;
        m   = MASK_RS1 | MASK_RD;
      end
      default: begin
        h   = {4'b1001, x[11:7], rs2nz, 2'b10};
        cls = OP_REG;
        m   = MASK_RS1 | MASK_RS2 | MASK_RD;
      end
    endcase
    w = {x[31:16], h};
  endtask

  // Words outside every table, all INVALID
  task automatic gen_invalid(output xlen_t w, output logic comp);
    xlen_t       x;
    int unsigned k2;
    x    = $urandom;
    comp = 1'b0;
    case ($urandom_range(4, 0))
      0: begin
        k2 = $urandom_range(2, 0);
        w  = {x[31:15], BAD_LD_F3[3*k2 +: 3], x[11:7], 7'b0000011};
      end
      1: w = {x[31:15], 3'($urandom_range(7, 3)), x[11:7], 7'b0100011};
      2: begin
        // c.unimp
        w    = {x[31:16], 16'h0000};
        comp = 1'b1;
      end
      3: begin
        k2 = $urandom_range(7, 0);
        w  = {x[31:7], RSV_OPC[5*k2 +: 5], 2'b11};
      end
      default: begin
        // Reserved or FP funct3 in quadrants 0 and 2
        w    = {x[31:16], x[15:14], 1'b1, x[12:2], x[0] ? 2'b10 : 2'b00};
        comp = 1'b1;
      end
    endcase
  endtask

  task automatic drive_cycle(input logic retire_now);
    xlen_t         w;
    xlen_t         pc;
    xlen_t         imm;
    insn_class_e   cls;
    access_mask_t  m;
    logic          comp;
    int unsigned   pick;
    trace_record_t exp;
    exp  = '0;
    pc   = $urandom;
    pc[0] = 1'b0;
    imm  = '0;
    cls  = INVALID;
    m    = MASK_NONE;
    comp = 1'b0;
    w    = $urandom;
    if (retire_now) begin
      pick = $urandom_range(99, 0);
      if (pick < 10) begin
        gen_invalid(w, comp);
      end else if (pick < 55) begin
        gen_full(w, cls, m, imm);
      end else begin
        gen_comp(w, cls, m, imm);
        comp = 1'b1;
      end
      exp.pc         = pc;
      exp.insn       = comp ? {16'b0, w[15:0]} : w;
      exp.compressed = comp;
      exp.insn_class = cls;
      exp.mask       = m;
      exp.imm        = imm;
      exp.target     = (cls == BRANCH || cls == JUMP) ? pc + imm : '0;
    end
    exp.valid = retire_now;
    exp.cycle = model_cycle;
    exp_q.push_back(exp);
    model_cycle++;
    rvfi_valid    = retire_now;
    rvfi_pc_rdata = pc;
    rvfi_insn     = w;
  endtask

  task automatic compare_next();
    trace_record_t exp;
    exp = exp_q.pop_front();
    check_flag(record.valid, exp.valid, "record valid");
    if (exp.valid) begin
      check_cycle(record.cycle, exp.cycle, "cycle stamp");
      check_word(record.pc, exp.pc, "pc");
      check_word(record.insn, exp.insn, "insn");
      check_flag(record.compressed, exp.compressed, $sformatf("compressed of %08h", exp.insn));
      check_class(record.insn_class, exp.insn_class, $sformatf("class of %08h", exp.insn));
      check_mask(record.mask, exp.mask, $sformatf("mask of %08h", exp.insn));
      check_word(record.imm, exp.imm, $sformatf("imm of %08h", exp.insn));
      check_word(record.target, exp.target, $sformatf("target of %08h", exp.insn));
    end
  endtask

  initial begin
    seed_ret      = $urandom(RAND_SEED);
    rst_ni        = 1'b0;
    // Strobe held high, so only the reset keeps the record invalid
    rvfi_valid    = 1'b1;
    rvfi_pc_rdata = '0;
    rvfi_insn     = '0;
    model_cycle   = '0;
    repeat (RESET_CYCLES) begin
      @(negedge clk_i);
      check_flag(record.valid, 1'b0, "record valid in reset");
    end
    rst_ni = 1'b1;
    // No retirement on the first edge after release
    drive_cycle(1'b0);
    for (int i = 0; i < NUM_CYCLES; i++) begin
      @(negedge clk_i);
      compare_next();
      drive_cycle($urandom_range(3, 0) != 0);
    end
    @(negedge clk_i);
    compare_next();
    $display("TEST PASSED");
    $finish;
  end

  initial begin
    #(WATCHDOG_NS);
    $display("watchdog expired after %0d ns before the run finished", WATCHDOG_NS);
    $display("TEST FAILED");
    $fatal(1, "watchdog timeout");
  end

endmodule

/* hdl/rvfi_tracer.sv */
// ******************************
// RVFI retirement tracer
// Decodes each retired instruction
// into one trace record per cycle
// ******************************

`timescale 1ns/1ns

module rvfi_tracer (
  input  logic                          clk_i,
  input  logic                          rst_ni,
  input  logic                          rvfi_valid,
  input  rvfi_trace_pkg::xlen_t         rvfi_pc_rdata,
  input  rvfi_trace_pkg::xlen_t         rvfi_insn,
  output rvfi_trace_pkg::trace_record_t record
);

  import rvfi_trace_pkg::*;

  rvfi_retire_t retire;
  insn_decode_t dec_full;
  insn_decode_t dec_comp;

  assign retire.valid = rvfi_valid;
  assign retire.pc    = rvfi_pc_rdata;

  // Both decodes run in parallel, the record unit picks one
  rv32_insn_decoder rv32_insn_decoder_inst (
    .insn (rvfi_insn),
    .dec  (dec_full)
  );

  rvc_insn_decoder rvc_insn_decoder_inst (
    .insn (rvfi_insn),
    .dec  (dec_comp)
  );

  trace_record_unit trace_record_unit_inst (
    .clk_i    (clk_i),
    .rst_ni   (rst_ni),
    .retire   (retire),
    .insn     (rvfi_insn),
    .dec_full (dec_full),
    .dec_comp (dec_comp),
    .record   (record)
  );

endmodule

/* hdl/trace_record_unit.sv */
// ******************************
// Trace record unit
// Cycle counter, decode select,
// control-flow target and the
// registered trace record
// ******************************

`timescale 1ns/1ns

`include "rvfi_trace_params.svh"

module trace_record_unit (
  input  logic                          clk_i,
  input  logic                          rst_ni,
  input  rvfi_trace_pkg::rvfi_retire_t  retire,
  input  rvfi_trace_pkg::xlen_t         insn,
  input  rvfi_trace_pkg::insn_decode_t  dec_full,
  input  rvfi_trace_pkg::insn_decode_t  dec_comp,
  output rvfi_trace_pkg::trace_record_t record
);

  import rvfi_trace_pkg::*;

  cycle_t        cycle_q;
  logic          is_compressed;
  insn_decode_t  dec_sel;
  logic          has_target;
  xlen_t         target;
  xlen_t         insn_trace;
  trace_record_t record_d;
  trace_record_t record_q;

  // Free running from reset
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      cycle_q <= cycle_t'(`TRACE_CYCLE_RESET);
    end else begin
      cycle_q <= cycle_q + cycle_t'(1);
    end
  end

  // Any low bit pair other than 11 marks a 16-bit instruction
  assign is_compressed = (insn[1:0] != 2'b11);
  assign dec_sel       = is_compressed ? dec_comp : dec_full;

  // Only pc-relative branches and jumps get a target
  assign has_target = (dec_sel.insn_class == BRANCH) || (dec_sel.insn_class == JUMP);
  assign target     = has_target ? retire.pc + dec_sel.imm : '0;

  assign insn_trace = is_compressed ? {{(`TRACE_XLEN-16){1'b0}}, insn[15:0]} : insn;

  always_comb begin
    record_d.valid      = retire.valid;
    record_d.cycle      = cycle_q;
    record_d.pc         = retire.pc;
    record_d.insn       = insn_trace;
    record_d.compressed = is_compressed;
    record_d.insn_class = dec_sel.insn_class;
    record_d.mask       = dec_sel.mask;
    record_d.imm        = dec_sel.imm;
    record_d.target     = target;
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      record_q <= '0;
    end else begin
      record_q <= record_d;
    end
  end

  assign record = record_q;

endmodule

/* hdl/rvc_insn_decoder.sv */
// ******************************
// RV32C instruction decoder
// Maps a 16-bit compressed word
// onto the shared classes, access
// mask and byte offset immediate
// ******************************

`timescale 1ns/1ns

module rvc_insn_decoder (
  input  rvfi_trace_pkg::xlen_t        insn,
  output rvfi_trace_pkg::insn_decode_t dec
);

  import rvfi_trace_pkg::*;

  localparam logic [1:0] QUAD_C0 = 2'b00;
  localparam logic [1:0] QUAD_C1 = 2'b01;
  localparam logic [1:0] QUAD_C2 = 2'b10;

  // Stack pointer index, selects c.addi16sp over c.lui
  localparam logic [4:0] REG_SP = 5'd2;

  logic [1:0] quadrant;
  logic [2:0] funct3;
  logic [4:0] rd_field;
  logic [4:0] rs2_field;

  xlen_t imm_ci;
  xlen_t imm_shamt;
  xlen_t imm_addi4spn;
  xlen_t imm_addi16sp;
  xlen_t imm_lui;
  xlen_t imm_lw;
  xlen_t imm_lwsp;
  xlen_t imm_swsp;
  xlen_t imm_cj;
  xlen_t imm_cb;

  assign quadrant  = insn[1:0];
  assign funct3    = insn[15:13];
  assign rd_field  = insn[11:7];
  assign rs2_field = insn[6:2];

  // Offsets as the ISA scatters them over the word
  assign imm_ci       = {{26{insn[12]}}, insn[12], insn[6:2]};
  assign imm_shamt    = {26'b0, insn[12], insn[6:2]};
  assign imm_addi4spn = {22'b0, insn[10:7], insn[12:11], insn[5], insn[6], 2'b00};
  assign imm_addi16sp = {{22{insn[12]}}, insn[12], insn[4:3], insn[5], insn[2], insn[6], 4'b0};
  assign imm_lui      = {{14{insn[12]}}, insn[12], insn[6:2], 12'b0};
  assign imm_lw       = {25'b0, insn[5], insn[12:10], insn[6], 2'b00};
  assign imm_lwsp     = {24'b0, insn[3:2], insn[12], insn[6:4], 2'b00};
  assign imm_swsp     = {24'b0, insn[8:7], insn[12:9], 2'b00};
  assign imm_cj = {{20{insn[12]}}, insn[12], insn[8], insn[10:9], insn[6], insn[7], insn[2],
                   insn[11], insn[5:3], 1'b0};
  assign imm_cb = {{23{insn[12]}}, insn[12], insn[6:5], insn[2], insn[11:10], insn[4:3], 1'b0};

  always_comb begin
    dec = make_decode(INVALID, MASK_NONE, '0);
    case (quadrant)
      QUAD_C0: begin
        case (funct3)
          3'b000: begin
            // All zero payload is c.unimp
            if (insn[12:2] != 11'b0) begin
              dec = make_decode(OP_IMM, MASK_RD, imm_addi4spn);
            end
          end
          3'b010: dec = make_decode(LOAD, MASK_RS1 | MASK_RD | MASK_MEM, imm_lw);
          3'b110: dec = make_decode(STORE, MASK_RS1 | MASK_RS2 | MASK_MEM, imm_lw);
          default: ;
        endcase
      end
      QUAD_C1: begin
        case (funct3)
          3'b000: dec = make_decode(OP_IMM, MASK_RS1 | MASK_RD, imm_ci);
          3'b001: dec = make_decode(JUMP, MASK_RD, imm_cj);
          3'b010: dec = make_decode(OP_IMM, MASK_RD, imm_ci);
          3'b011: begin
            if (rd_field == REG_SP) begin
              dec = make_decode(OP_IMM, MASK_RS1 | MASK_RD, imm_addi16sp);
            end else begin
              dec = make_decode(UPPER, MASK_RD, imm_lui);
            end
          end
          3'b100: begin
            case (insn[11:10])
              2'b00, 2'b01: dec = make_decode(OP_SHIFT_IMM, MASK_RS1 | MASK_RD, imm_shamt);
              2'b10:        dec = make_decode(OP_IMM, MASK_RS1 | MASK_RD, imm_ci);
              default: begin
                // c.sub, c.xor, c.or, c.and; bit 12 set is RV64 only
                if (!insn[12]) begin
                  dec = make_decode(OP_REG, MASK_RS1 | MASK_RS2 | MASK_RD, '0);
                end
              end
            endcase
          end
          3'b101: dec = make_decode(JUMP, MASK_NONE, imm_cj);
          default: dec = make_decode(BRANCH, MASK_RS1, imm_cb);
        endcase
      end
      QUAD_C2: begin
        case (funct3)
          3'b000: dec = make_decode(OP_SHIFT_IMM, MASK_RS1 | MASK_RD, imm_shamt);
          3'b010: dec = make_decode(LOAD, MASK_RS1 | MASK_RD | MASK_MEM, imm_lwsp);
          3'b100: begin
            if (!insn[12]) begin
              if (rs2_field == 5'd0) begin
                dec = make_decode(JUMP_REG, MASK_RS1, '0);
              end else begin
                // c.mv
                dec = make_decode(OP_REG, MASK_RS2 | MASK_RD, '0);
              end
            end else if (insn[11:2] == 10'b0) begin
              dec = make_decode(SYSTEM, MASK_NONE, '0);
            end else if (rs2_field == 5'd0) begin
              dec = make_decode(JUMP_REG, MASK_RS1 | MASK_RD, '0);
            end else begin
              dec = make_decode(OP_REG, MASK_RS1 | MASK_RS2 | MASK_RD, '0);
            end
          end
          3'b110: dec = make_decode(STORE, MASK_RS1 | MASK_RS2 | MASK_MEM, imm_swsp);
          default: ;
        endcase
      end
      default: ;
    endcase
  end

endmodule

/* hdl/rv32_insn_decoder.sv */
// ******************************
// RV32 instruction decoder
// Maps a 32-bit word onto class,
// access mask and immediate
// ******************************

`timescale 1ns/1ns

module rv32_insn_decoder (
  input  rvfi_trace_pkg::xlen_t        insn,
  output rvfi_trace_pkg::insn_decode_t dec
);

  import rvfi_trace_pkg::*;

  // Major opcodes, instruction bits [6:2]
  localparam logic [4:0] OPC_LOAD     = 5'b00000;
  localparam logic [4:0] OPC_MISC_MEM = 5'b00011;
  localparam logic [4:0] OPC_OP_IMM   = 5'b00100;
  localparam logic [4:0] OPC_AUIPC    = 5'b00101;
  localparam logic [4:0] OPC_STORE    = 5'b01000;
  localparam logic [4:0] OPC_OP       = 5'b01100;
  localparam logic [4:0] OPC_LUI      = 5'b01101;
  localparam logic [4:0] OPC_BRANCH   = 5'b11000;
  localparam logic [4:0] OPC_JALR     = 5'b11001;
  localparam logic [4:0] OPC_JAL      = 5'b11011;
  localparam logic [4:0] OPC_SYSTEM   = 5'b11100;

  localparam logic [6:0] F7_BASE = 7'b0000000;
  localparam logic [6:0] F7_ALT  = 7'b0100000;
  localparam logic [6:0] F7_MULDIV = 7'b0000001;

  // funct12 of the privileged system instructions
  localparam logic [11:0] F12_ECALL  = 12'h000;
  localparam logic [11:0] F12_EBREAK = 12'h001;
  localparam logic [11:0] F12_MRET   = 12'h302;
  localparam logic [11:0] F12_DRET   = 12'h7b2;
  localparam logic [11:0] F12_WFI    = 12'h105;

  logic [4:0]  opcode;
  logic [2:0]  funct3;
  logic [6:0]  funct7;
  logic [11:0] funct12;

  xlen_t imm_i;
  xlen_t imm_s;
  xlen_t imm_b;
  xlen_t imm_u;
  xlen_t imm_j;
  xlen_t imm_shamt;
  xlen_t imm_uimm;

  assign opcode  = insn[6:2];
  assign funct3  = insn[14:12];
  assign funct7  = insn[31:25];
  assign funct12 = insn[31:20];

  // Immediates of every format, selected below
  assign imm_i = {{20{insn[31]}}, insn[31:20]};
  assign imm_s = {{20{insn[31]}}, insn[31:25], insn[11:7]};
  assign imm_b = {{19{insn[31]}}, insn[31], insn[7], insn[30:25], insn[11:8], 1'b0};
  assign imm_u = {insn[31:12], 12'b0};
  assign imm_j = {{11{insn[31]}}, insn[31], insn[19:12], insn[20], insn[30:21], 1'b0};
  assign imm_shamt = {27'b0, insn[24:20]};
  assign imm_uimm  = {27'b0, insn[19:15]};

  always_comb begin
    dec = make_decode(INVALID, MASK_NONE, '0);
    case (opcode)
      OPC_LUI, OPC_AUIPC: dec = make_decode(UPPER, MASK_RD, imm_u);
      OPC_JAL:            dec = make_decode(JUMP, MASK_RD, imm_j);
      OPC_JALR: begin
        if (funct3 == 3'b000) begin
          dec = make_decode(JUMP_REG, MASK_RS1 | MASK_RD, imm_i);
        end
      end
      OPC_BRANCH: begin
        // funct3 010 and 011 are reserved
        if (funct3[2:1] != 2'b01) begin
          dec = make_decode(BRANCH, MASK_RS1 | MASK_RS2, imm_b);
        end
      end
      OPC_LOAD: begin
        case (funct3)
          3'b000, 3'b001, 3'b010, 3'b100, 3'b101: begin
            dec = make_decode(LOAD, MASK_RS1 | MASK_RD | MASK_MEM, imm_i);
          end
          default: ;
        endcase
      end
      OPC_STORE: begin
        case (funct3)
          3'b000, 3'b001, 3'b010: dec = make_decode(STORE, MASK_RS1 | MASK_RS2 | MASK_MEM, imm_s);
          default: ;
        endcase
      end
      OPC_OP_IMM: begin
        case (funct3)
          3'b001: begin
            if (funct7 == F7_BASE) begin
              dec = make_decode(OP_SHIFT_IMM, MASK_RS1 | MASK_RD, imm_shamt);
            end
          end
          // srli or srai
          3'b101: begin
            if (funct7 == F7_BASE || funct7 == F7_ALT) begin
              dec = make_decode(OP_SHIFT_IMM, MASK_RS1 | MASK_RD, imm_shamt);
            end
          end
          default: dec = make_decode(OP_IMM, MASK_RS1 | MASK_RD, imm_i);
        endcase
      end
      OPC_OP: begin
        // Base ALU and the M group share this opcode
        if (funct7 == F7_BASE || funct7 == F7_MULDIV) begin
          dec = make_decode(OP_REG, MASK_RS1 | MASK_RS2 | MASK_RD, '0);
        end else if (funct7 == F7_ALT && (funct3 == 3'b000 || funct3 == 3'b101)) begin
          dec = make_decode(OP_REG, MASK_RS1 | MASK_RS2 | MASK_RD, '0);
        end
      end
      OPC_MISC_MEM: begin
        if (funct3 == 3'b000) begin
          dec = make_decode(FENCE, MASK_NONE, '0);
        end else if (funct3 == 3'b001) begin
          // fence.i
          dec = make_decode(SYSTEM, MASK_NONE, '0);
        end
      end
      OPC_SYSTEM: begin
        case (funct3)
          3'b000: begin
            case (funct12)
              F12_ECALL, F12_EBREAK, F12_MRET, F12_DRET, F12_WFI: begin
                dec = make_decode(SYSTEM, MASK_NONE, '0);
              end
              default: ;
            endcase
          end
          // Immediate carries the CSR address
          3'b001, 3'b010, 3'b011: dec = make_decode(CSR_REG, MASK_RS1 | MASK_RD, imm_i);
          3'b101, 3'b110, 3'b111: dec = make_decode(CSR_IMM, MASK_RD, imm_uimm);
          default: ;
        endcase
      end
      default: ;
    endcase
  end

endmodule

/* hdl/rvfi_trace_pkg.sv */
// ******************************
// Retirement tracer package
// Word types, instruction classes
// and the retire, decode and trace
// record structs
// ******************************

`include "rvfi_trace_params.svh"

package rvfi_trace_pkg;

  typedef logic [`TRACE_XLEN-1:0]       xlen_t;
  typedef logic [`TRACE_REG_ADDR_W-1:0] reg_addr_t;
  typedef logic [`TRACE_CYCLE_W-1:0]    cycle_t;

  // Bit 0 rs1, bit 1 rs2, bit 2 rd, bit 3 mem
  typedef logic [3:0] access_mask_t;

  localparam access_mask_t MASK_NONE = 4'b0000;
  localparam access_mask_t MASK_RS1  = 4'b0001;
  localparam access_mask_t MASK_RS2  = 4'b0010;
  localparam access_mask_t MASK_RD   = 4'b0100;
  localparam access_mask_t MASK_MEM  = 4'b1000;

  typedef enum logic [3:0] {
    INVALID      = 4'd0,
    UPPER        = 4'd1,
    JUMP         = 4'd2,
    JUMP_REG     = 4'd3,
    BRANCH       = 4'd4,
    LOAD         = 4'd5,
    STORE        = 4'd6,
    OP_IMM       = 4'd7,
    OP_SHIFT_IMM = 4'd8,
    OP_REG       = 4'd9,
    CSR_REG      = 4'd10,
    CSR_IMM      = 4'd11,
    FENCE        = 4'd12,
    SYSTEM       = 4'd13
  } insn_class_e;

  // Strobe and PC of one retirement
  typedef struct packed {
    logic  valid;
    xlen_t pc;
  } rvfi_retire_t;

  typedef struct packed {
    insn_class_e  insn_class;
    access_mask_t mask;
    xlen_t        imm;
  } insn_decode_t;

  typedef struct packed {
    logic         valid;
    cycle_t       cycle;
    xlen_t        pc;
    xlen_t        insn;
    logic         compressed;
    insn_class_e  insn_class;
    access_mask_t mask;
    xlen_t        imm;
    xlen_t        target;
  } trace_record_t;

  // Builds one decode result, shared by both decoders
  function automatic insn_decode_t make_decode(insn_class_e cls, access_mask_t acc, xlen_t imm);
    insn_decode_t d;
    d.insn_class = cls;
    d.mask       = acc;
    d.imm        = imm;
    return d;
  endfunction

endpackage

/* include/rvfi_trace_params.svh */
// ******************************
// Retirement tracer parameters
// Widths of the traced words, the
// register index and cycle stamp
// ******************************

`ifndef RVFI_TRACE_PARAMS_SVH
`define RVFI_TRACE_PARAMS_SVH

// Data and address width of the traced core
`define TRACE_XLEN 32

// Cycle stamp width and its value after reset
`define TRACE_CYCLE_W 32
`define TRACE_CYCLE_RESET 0

// Register index width
`define TRACE_REG_ADDR_W 5

`endif
